//--- common/u712_params.svh
// Timing counts and address field positions, included by the cycle engines
`ifndef U712_PARAMS_SVH
`define U712_PARAMS_SVH

// Register cycle
// clk80 cycles with AS and the data strobes low
`define REG_HOLD_CYCLES 16

// Chip RAM cycle
// clk80 cycles from RAS low to CAS low
`define RAS_TO_CAS 2
// clk80 cycles CAS stays low before the acknowledge
`define CAS_HOLD 3

// Address fields
// Lowest row address bit, column is below it
`define ROW_LSB 10
// Chip RAM bank select
`define BANK_BIT 20

`endif

//--- common/u712Pkg.sv
// Shared bus-bridge types, imported by the RTL blocks and the testbench
package u712Pkg;

    // 68040 transfer size codes from SIZ[1:0]
    // Line transfers run as long transfers on this card
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } transferSizeT;

    // CPU request as held on the local bus until tackN
    typedef struct packed {
        logic [20:0]  addr;
        logic         rnw;
        transferSizeT siz;
    } cpuReqT;

    // Chipset register cycle, 68000 style strobes
    typedef enum logic [2:0] {
        regIdle,
        regSync,
        regStrobe,
        regHold,
        regAck
    } regStateT;

    // Chip RAM row/column cycle
    typedef enum logic [2:0] {
        ramIdle,
        ramRas,
        ramCas,
        ramHold,
        ramAck
    } ramStateT;

    // DRAM control pins, all active low except the clock enable
    typedef struct packed {
        logic rasN;
        logic casN;
        logic weN;
        logic clkEn;
        logic ramEnN;
    } ramStrobesT;

endpackage

//--- design/busSteering.sv
// Byte-lane enables and data-buffer controls, decoded straight from the CPU request
`timescale 1ns/100ps

module busSteering import u712Pkg::*; (
    input  cpuReqT req,
    input  logic   regSpaceN,
    input  logic   ramSpaceN,
    input  logic   dbDir,
    output logic   cuubeN,
    output logic   cumbeN,
    output logic   clmbeN,
    output logic   cllbeN,
    output logic   vbenN,
    output logic   drdenN,
    output logic   drdDir
);

    // Lane 0 is the uppermost byte, D31..D24
    logic [0:3] laneN;

    always_comb begin
        laneN = 4'b1111;
        case (req.siz)
            sizeByte: laneN[req.addr[1:0]] = 1'b0;
            // Word picks a half by A1
            sizeWord: laneN = req.addr[1] ? 4'b1100 : 4'b0011;
            // Long and line use all four lanes
            default:  laneN = 4'b0000;
        endcase
    end

    assign cuubeN = laneN[0];
    assign cumbeN = laneN[1];
    assign clmbeN = laneN[2];
    assign cllbeN = laneN[3];

    // Chipset register buffer
    assign vbenN  = regSpaceN;
    // Chip RAM data buffer
    assign drdenN = ramSpaceN;
    // Direction comes from the local bus side
    assign drdDir = dbDir;

endmodule

//--- regCycle/regCycle.sv
// Chipset register cycle engine, runs the 68000 strobe sequence in step with c1/c3
`timescale 1ns/100ps
`include "u712_params.svh"

module regCycle import u712Pkg::*; (
    input  logic   clk80,
    input  logic   reset,
    input  logic   c1,
    input  logic   c3,
    input  logic   tsN,
    input  logic   regSpaceN,
    input  logic   dbrN,
    input  cpuReqT req,
    output logic   asN,
    output logic   udsN,
    output logic   ldsN,
    output logic   regEnN,
    output logic   regTack
);

    localparam int holdW = $clog2(`REG_HOLD_CYCLES) + 1;

    regStateT         state;
    logic [holdW-1:0] holdCnt;
    logic             udsSel;
    logic             ldsSel;
    logic             startReq;
    logic             phaseOk;
    logic             strobing;
    logic             byteAcc;

    // New register access from the CPU, only while DMA leaves the bus free
    assign startReq = !tsN && !regSpaceN && dbrN;
    // Chipset phase where AS may fall
    assign phaseOk  = c1 && !c3;
    assign byteAcc  = (req.siz == sizeByte);

    //////////////////////////////////////////////////
    // Cycle state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk80) begin
        if (reset) begin
            state   <= regIdle;
            holdCnt <= '0;
        end else begin
            case (state)
                regIdle: begin
                    if (startReq) begin
                        state <= regSync;
                    end
                end
                // Wait for c1 high, c3 low
                regSync: begin
                    if (phaseOk) begin
                        state   <= regStrobe;
                        holdCnt <= '0;
                    end
                end
                // First strobe cycle
                regStrobe: begin
                    state   <= regHold;
                    holdCnt <= holdCnt + 1'b1;
                end
                regHold: begin
                    if (holdCnt == holdW'(`REG_HOLD_CYCLES - 1)) begin
                        state <= regAck;
                    end else begin
                        holdCnt <= holdCnt + 1'b1;
                    end
                end
                // Strobes already up, one-cycle acknowledge
                regAck: begin
                    state <= regIdle;
                end
                default: begin
                    state <= regIdle;
                end
            endcase
        end
    end

    // Lane choice taken at the start, held for the cycle
    always_ff @(posedge clk80) begin
        if (state == regIdle && startReq) begin
            udsSel <= !byteAcc || !req.addr[0];
            ldsSel <= !byteAcc || req.addr[0];
        end
    end

    //////////////////////////////////////////////////
    // Strobe outputs
    //////////////////////////////////////////////////

    assign strobing = (state == regStrobe) || (state == regHold);

    assign asN     = !strobing;
    assign regEnN  = !strobing;
    // Even byte on UDS, odd byte on LDS
    assign udsN    = !(strobing && udsSel);
    assign ldsN    = !(strobing && ldsSel);
    assign regTack = (state == regAck);

endmodule

//--- chipRam/chipRam.sv
// Chip RAM cycle engine, one RAS/CAS access with row/column address multiplexing
`timescale 1ns/100ps
`include "u712_params.svh"

module chipRam import u712Pkg::*; (
    input  logic        clk80,
    input  logic        reset,
    input  logic        tsN,
    input  logic        ramSpaceN,
    input  logic        dbrN,
    input  cpuReqT      req,
    output ramStrobesT  strobes,
    output logic [10:0] cma,
    output logic        bank0,
    output logic        bank1,
    output logic        crcsN,
    output logic        ramTack
);

    localparam int maxCnt = (`CAS_HOLD > `RAS_TO_CAS) ? `CAS_HOLD : `RAS_TO_CAS;
    localparam int cntW   = $clog2(maxCnt) + 1;

    ramStateT        state;
    logic [cntW-1:0] cycCnt;
    logic            pending;
    logic            startReq;
    logic            busy;
    logic            casPhase;
    logic [10:0]     rowAddr;
    logic [10:0]     colAddr;

    assign startReq = !tsN && !ramSpaceN;

    //////////////////////////////////////////////////
    // Cycle state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk80) begin
        if (reset) begin
            state   <= ramIdle;
            cycCnt  <= '0;
            pending <= 1'b0;
        end else begin
            case (state)
                ramIdle: begin
                    // Agnus owns the bus while dbrN is low
                    if ((startReq || pending) && dbrN) begin
                        state   <= ramRas;
                        cycCnt  <= '0;
                        pending <= 1'b0;
                    end else if (startReq) begin
                        pending <= 1'b1;
                    end
                end
                // Row address out, RAS low
                ramRas: begin
                    if (cycCnt == cntW'(`RAS_TO_CAS - 1)) begin
                        state  <= ramCas;
                        cycCnt <= '0;
                    end else begin
                        cycCnt <= cycCnt + 1'b1;
                    end
                end
                // Column address out, CAS falls here
                ramCas: begin
                    state  <= (`CAS_HOLD > 1) ? ramHold : ramAck;
                    cycCnt <= cntW'(1);
                end
                ramHold: begin
                    if (cycCnt == cntW'(`CAS_HOLD - 1)) begin
                        state <= ramAck;
                    end else begin
                        cycCnt <= cycCnt + 1'b1;
                    end
                end
                // All strobes up, acknowledge for one cycle
                ramAck: begin
                    state <= ramIdle;
                end
                default: begin
                    state <= ramIdle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Address mux and strobes
    //////////////////////////////////////////////////

    assign busy     = (state == ramRas) || (state == ramCas) || (state == ramHold);
    assign casPhase = (state == ramCas) || (state == ramHold);

    // Row is A19..A10, top bit stays low
    assign rowAddr = {1'b0, req.addr[`ROW_LSB +: 10]};
    // Column is A9..A1, word addressed
    assign colAddr = {2'b00, req.addr[`ROW_LSB-1:1]};
    assign cma     = casPhase ? colAddr : rowAddr;

    assign strobes.rasN   = !busy;
    assign strobes.casN   = !casPhase;
    // Early write, WE falls with CAS
    assign strobes.weN    = !(casPhase && !req.rnw);
    assign strobes.clkEn  = busy;
    assign strobes.ramEnN = !busy;

    // Bank select from A20
    assign bank0   = busy && !req.addr[`BANK_BIT];
    assign bank1   = busy && req.addr[`BANK_BIT];
    assign crcsN   = !busy;
    assign ramTack = (state == ramAck);

endmodule

//--- design/cycleTerm.sv
// CPU cycle termination, merges both acknowledges into a tackN pulse on the 40 MHz phase
`timescale 1ns/100ps

module cycleTerm (
    input  logic clk80,
    input  logic reset,
    input  logic regTack,
    input  logic ramTack,
    output logic tackN
);

    logic phase;
    logic pending;
    logic holdTack;
    logic anyAck;

    assign anyAck = regTack || ramTack;

    always_ff @(posedge clk80) begin
        if (reset) begin
            phase    <= 1'b0;
            pending  <= 1'b0;
            holdTack <= 1'b0;
            tackN    <= 1'b1;
        end else begin
            // 40 MHz phase from clk80
            phase <= !phase;
            if (holdTack) begin
                // Second low cycle
                holdTack <= 1'b0;
            end else if (!tackN) begin
                tackN <= 1'b1;
            end else if ((pending || anyAck) && !phase) begin
                // Start only on phase 0
                tackN    <= 1'b0;
                holdTack <= 1'b1;
                pending  <= 1'b0;
            end else if (anyAck) begin
                pending <= 1'b1;
            end
        end
    end

endmodule

//--- design/u712Top.sv
// Bus bridge top level, wires the cycle engines, termination and steering to the pins
`timescale 1ns/100ps

module u712Top import u712Pkg::*; (
    input  logic        clk80,
    input  logic        reset,
    input  logic        c1,
    input  logic        c3,
    input  logic        tsN,
    input  logic        dbrN,
    input  logic        regSpaceN,
    input  logic        ramSpaceN,
    input  logic        dbDir,
    input  logic        rnw,
    input  logic [1:0]  siz,
    input  logic [20:0] addr,
    output logic        asN,
    output logic        udsN,
    output logic        ldsN,
    output logic        regEnN,
    output logic        vbenN,
    output logic        drdenN,
    output logic        drdDir,
    output logic        dbenN,
    output logic        crcsN,
    output logic        clkEn,
    output logic        bank0,
    output logic        bank1,
    output logic        rasN,
    output logic        casN,
    output logic        weN,
    output logic        ramEnN,
    output logic [10:0] cma,
    output logic        cuubeN,
    output logic        cumbeN,
    output logic        clmbeN,
    output logic        cllbeN,
    output logic        tackN
);

    cpuReqT     req;
    ramStrobesT ramStrobes;
    logic       regTack;
    logic       ramTack;

    // Request fields from the local bus pins
    assign req.addr = addr;
    assign req.rnw  = rnw;
    assign req.siz  = transferSizeT'(siz);

    // DRAM strobes out to the pins
    assign rasN   = ramStrobes.rasN;
    assign casN   = ramStrobes.casN;
    assign weN    = ramStrobes.weN;
    assign clkEn  = ramStrobes.clkEn;
    assign ramEnN = ramStrobes.ramEnN;

    // Not used on this board revision
    assign dbenN = 1'b1;

    //////////////////////////////////////////////////
    // Cycle engines
    //////////////////////////////////////////////////

    regCycle regCycle_i (
        .clk80(clk80), .reset(reset), .c1(c1), .c3(c3), .tsN(tsN),
        .regSpaceN(regSpaceN), .dbrN(dbrN), .req(req),
        .asN(asN), .udsN(udsN), .ldsN(ldsN), .regEnN(regEnN), .regTack(regTack)
    );

    chipRam chipRam_i (
        .clk80(clk80), .reset(reset), .tsN(tsN), .ramSpaceN(ramSpaceN),
        .dbrN(dbrN), .req(req), .strobes(ramStrobes), .cma(cma),
        .bank0(bank0), .bank1(bank1), .crcsN(crcsN), .ramTack(ramTack)
    );

    // Termination and lane steering
    cycleTerm cycleTerm_i (
        .clk80(clk80), .reset(reset), .regTack(regTack), .ramTack(ramTack), .tackN(tackN)
    );

    busSteering busSteering_i (
        .req(req), .regSpaceN(regSpaceN), .ramSpaceN(ramSpaceN), .dbDir(dbDir),
        .cuubeN(cuubeN), .cumbeN(cumbeN), .clmbeN(clmbeN), .cllbeN(cllbeN),
        .vbenN(vbenN), .drdenN(drdenN), .drdDir(drdDir)
    );

endmodule

//--- sim/u712Tb.sv
// Table-driven testbench for the bus bridge, built and run through the Makefile
`timescale 1ns/100ps
`include "u712_params.svh"

module u712Tb import u712Pkg::*; ();

    typedef enum logic {spaceReg, spaceRam} spaceT;

    // One table row, request plus expected lanes and data strobes
    typedef struct packed {
        spaceT        space;
        logic         rnw;
        transferSizeT siz;
        logic [20:0]  addr;
        logic [3:0]   dmaHold;
        logic [3:0]   lanesN;
        logic [1:0]   dsN;
    } rowT;

    logic        clk80;
    logic        reset;
    logic        c1;
    logic        c3;
    logic        tsN;
    logic        dbrN;
    logic        regSpaceN;
    logic        ramSpaceN;
    logic        dbDir;
    logic        rnw;
    logic [1:0]  siz;
    logic [20:0] addr;
    logic        asN, udsN, ldsN, regEnN, vbenN, drdenN, drdDir, dbenN;
    logic        crcsN, clkEn, bank0, bank1, rasN, casN, weN, ramEnN, tackN;
    logic        cuubeN, cumbeN, clmbeN, cllbeN;
    logic [10:0] cma;

    logic [2:0]  chipDiv;
    logic        lastPhaseOk;
    logic        tableReady;
    integer      seed;
    rowT         rows[$];

    u712Top dut_i (.*);

    // 80 MHz local clock
    initial begin
        clk80 = 1'b0;
        forever #4 clk80 = ~clk80;
    end

    // Chipset clocks, c3 leads c1 by a quarter period
    always @(negedge clk80) begin
        chipDiv <= chipDiv + 1'b1;
    end
    assign c1 = chipDiv[2];
    assign c3 = chipDiv[2] ^ chipDiv[1];

    // Phase seen by the DUT at the last rising edge
    always @(posedge clk80) begin
        lastPhaseOk <= c1 && !c3;
    end

    //////////////////////////////////////////////////
    // Checks and expected values
    //////////////////////////////////////////////////

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Lane 0 uppermost, all low for long and line
    function automatic logic [3:0] laneRule(transferSizeT sz, logic [20:0] a);
        logic [3:0] lanes;
        case (sz)
            sizeByte: lanes = 4'b1111 ^ (4'b1000 >> a[1:0]);
            sizeWord: lanes = a[1] ? 4'b1100 : 4'b0011;
            default:  lanes = 4'b0000;
        endcase
        return lanes;
    endfunction

    // {udsN, ldsN}, even byte on UDS
    function automatic logic [1:0] strobeRule(transferSizeT sz, logic [20:0] a);
        return (sz == sizeByte) ? {a[0], !a[0]} : 2'b00;
    endfunction

    task automatic checkIdle();
        checkEq("idle strobes {as,uds,lds,regEn,ras,cas,we,ramEn,crcs,tack}",
            32'({asN, udsN, ldsN, regEnN, rasN, casN, weN, ramEnN, crcsN, tackN}),
            32'h3FF);
    endtask

    task automatic addRow(input spaceT sp, input logic rw, input transferSizeT sz,
                          input logic [20:0] a, input logic [3:0] hold,
                          input logic [3:0] lanes, input logic [1:0] ds);
        rowT row;
        row = '{sp, rw, sz, a, hold, lanes, ds};
        rows.push_back(row);
    endtask

    task automatic loadTable();
        logic [20:0]  a;
        transferSizeT sz;
        spaceT        sp;
        logic         rw;
        logic [3:0]   hold;
        // Every size against every addr[1:0]
        addRow(spaceReg, 1'b1, sizeLong, 21'h0DFF00, 4'd0, 4'b0000, 2'b00);
        addRow(spaceRam, 1'b0, sizeLong, 21'h1A5C01, 4'd0, 4'b0000, 2'b00);
        addRow(spaceReg, 1'b0, sizeLong, 21'h0DF09A, 4'd0, 4'b0000, 2'b00);
        addRow(spaceRam, 1'b1, sizeLong, 21'h03C7FF, 4'd0, 4'b0000, 2'b00);
        addRow(spaceRam, 1'b1, sizeByte, 21'h12345C, 4'd0, 4'b0111, 2'b01);
        addRow(spaceReg, 1'b0, sizeByte, 21'h0DF0A1, 4'd0, 4'b1011, 2'b10);
        addRow(spaceRam, 1'b0, sizeByte, 21'h0F0F0E, 4'd0, 4'b1101, 2'b01);
        addRow(spaceReg, 1'b1, sizeByte, 21'h0DF01F, 4'd0, 4'b1110, 2'b10);
        addRow(spaceReg, 1'b1, sizeWord, 21'h0DF0A0, 4'd0, 4'b0011, 2'b00);
        addRow(spaceRam, 1'b0, sizeWord, 21'h155551, 4'd0, 4'b0011, 2'b00);
        addRow(spaceRam, 1'b1, sizeWord, 21'h0AAAA2, 4'd0, 4'b1100, 2'b00);
        addRow(spaceReg, 1'b0, sizeWord, 21'h0DF13F, 4'd0, 4'b1100, 2'b00);
        addRow(spaceRam, 1'b0, sizeLine, 21'h1FFFF0, 4'd0, 4'b0000, 2'b00);
        addRow(spaceReg, 1'b1, sizeLine, 21'h0DF005, 4'd0, 4'b0000, 2'b00);
        addRow(spaceRam, 1'b1, sizeLine, 21'h000402, 4'd0, 4'b0000, 2'b00);
        addRow(spaceReg, 1'b0, sizeLine, 21'h0DF1F7, 4'd0, 4'b0000, 2'b00);
        // Agnus holding the bus around tsN
        addRow(spaceRam, 1'b0, sizeWord, 21'h0B1234, 4'd3, 4'b0011, 2'b00);
        addRow(spaceRam, 1'b1, sizeByte, 21'h18E6D7, 4'd7, 4'b1110, 2'b10);
        // Random rows, DMA hold only on chip RAM
        for (int i = 0; i < 8; i++) begin
            a    = 21'($random(seed));
            sz   = transferSizeT'(2'($random(seed)));
            sp   = spaceT'(1'($random(seed)));
            rw   = 1'($random(seed));
            hold = (sp == spaceRam) ? 4'($unsigned($random(seed)) % 6) : 4'd0;
            addRow(sp, rw, sz, a, hold, laneRule(sz, a), strobeRule(sz, a));
        end
    endtask

    //////////////////////////////////////////////////
    // One CPU cycle, sampled on falling edges
    //////////////////////////////////////////////////

    task automatic runRow(input rowT r);
        int   k;
        int   rasFall;
        int   rasEnd;
        int   casFall;
        int   asEnd;
        int   tackFall;
        int   endK;
        int   tackLow;
        int   asLow;
        int   udsLow;
        int   ldsLow;
        int   regEnLow;
        int   casLow;
        int   rasLow;
        logic prevRas;
        logic prevCas;
        logic prevAs;
        logic prevTack;
        bit   ramLow;
        bit   done;
        k = 0;
        rasFall = -1;
        rasEnd = -1;
        casFall = -1;
        asEnd = -1;
        tackFall = -1;
        tackLow = 0;
        asLow = 0;
        udsLow = 0;
        ldsLow = 0;
        regEnLow = 0;
        casLow = 0;
        rasLow = 0;
        prevRas = 1'b1;
        prevCas = 1'b1;
        prevAs = 1'b1;
        prevTack = 1'b1;
        done = 1'b0;
        // Request held until tackN
        addr = r.addr;
        rnw = r.rnw;
        dbDir = r.rnw;
        siz = r.siz;
        regSpaceN = (r.space != spaceReg);
        ramSpaceN = (r.space != spaceRam);
        dbrN = (r.dmaHold == 4'd0);
        tsN = 1'b0;
        while (!done) begin
            @(negedge clk80);
            k++;
            if (k == 1) begin
                checkEq("byte lanes", 32'({cuubeN, cumbeN, clmbeN, cllbeN}), 32'(r.lanesN));
                checkEq("vbenN", 32'(vbenN), 32'(regSpaceN));
                checkEq("drdenN", 32'(drdenN), 32'(ramSpaceN));
                checkEq("drdDir", 32'(drdDir), 32'(dbDir));
                checkEq("dbenN", 32'(dbenN), 32'd1);
            end
            // Chip RAM window, from the release of dbrN through the CAS hold
            ramLow = (r.space == spaceRam) && (k > int'(r.dmaHold))
                && (k <= int'(r.dmaHold) + `RAS_TO_CAS + `CAS_HOLD);
            checkEq("crcsN", 32'(crcsN), 32'(!ramLow));
            checkEq("ramEnN", 32'(ramEnN), 32'(!ramLow));
            checkEq("clkEn", 32'(clkEn), 32'(ramLow));
            if (prevRas && !rasN) begin
                rasFall = k;
                checkEq("cma row", 32'(cma), 32'({1'b0, r.addr[`ROW_LSB +: 10]}));
                checkEq("bank0", 32'(bank0), 32'(!r.addr[`BANK_BIT]));
                checkEq("bank1", 32'(bank1), 32'(r.addr[`BANK_BIT]));
                checkEq("weN at RAS", 32'(weN), 32'd1);
            end
            if (!prevRas && rasN) rasEnd = k;
            if (prevCas && !casN) begin
                casFall = k;
                checkEq("cma column", 32'(cma), 32'({2'b00, r.addr[`ROW_LSB-1:1]}));
                checkEq("weN at CAS", 32'(weN), 32'(r.rnw));
            end
            if (prevAs && !asN) begin
                checkEq("c1 high c3 low at asN fall", 32'(lastPhaseOk), 32'd1);
            end
            if (!prevAs && asN) asEnd = k;
            if (prevTack && !tackN) tackFall = k;
            tackLow += int'(!tackN);
            asLow += int'(!asN);
            udsLow += int'(!udsN);
            ldsLow += int'(!ldsN);
            regEnLow += int'(!regEnN);
            casLow += int'(!casN);
            rasLow += int'(!rasN);
            done = (tackFall > 0) && tackN;
            prevRas = rasN;
            prevCas = casN;
            prevAs = asN;
            prevTack = tackN;
            // Inputs change only after sampling
            if (k == 1) tsN = 1'b1;
            if (k == int'(r.dmaHold)) dbrN = 1'b1;
        end
        checkEq("tackN low cycles", tackLow, 2);
        if (r.space == spaceReg) begin
            checkEq("asN low cycles", asLow, `REG_HOLD_CYCLES);
            checkEq("regEnN low cycles", regEnLow, `REG_HOLD_CYCLES);
            checkEq("udsN low cycles", udsLow, r.dsN[1] ? 0 : `REG_HOLD_CYCLES);
            checkEq("ldsN low cycles", ldsLow, r.dsN[0] ? 0 : `REG_HOLD_CYCLES);
            checkEq("rasN low cycles in register cycle", rasLow, 0);
            endK = asEnd;
        end else begin
            // rasN waits for dbrN, then the fixed strobe pattern
            checkEq("rasN fall cycle", rasFall, int'(r.dmaHold) + 1);
            checkEq("RAS to CAS cycles", casFall - rasFall, `RAS_TO_CAS);
            checkEq("casN low cycles", casLow, `CAS_HOLD);
            checkEq("rasN low cycles", rasEnd - rasFall, `RAS_TO_CAS + `CAS_HOLD);
            checkEq("asN low cycles in chip RAM cycle", asLow, 0);
            checkEq("regEnN low cycles in chip RAM cycle", regEnLow, 0);
            endK = rasEnd;
        end
        checkEq("tackN one or two cycles after ack",
            32'((tackFall - endK == 1) || (tackFall - endK == 2)), 32'd1);
        regSpaceN = 1'b1;
        ramSpaceN = 1'b1;
        dbrN = 1'b1;
        @(negedge clk80);
        checkIdle();
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        seed = 87617;
        tableReady = 1'b0;
        chipDiv = 3'd0;
        reset = 1'b1;
        tsN = 1'b1;
        dbrN = 1'b1;
        regSpaceN = 1'b1;
        ramSpaceN = 1'b1;
        dbDir = 1'b0;
        rnw = 1'b1;
        siz = 2'b00;
        addr = '0;
        loadTable();
        tableReady = 1'b1;
        repeat (16) @(posedge clk80);
        @(negedge clk80);
        reset = 1'b0;
        @(negedge clk80);
        checkIdle();
        foreach (rows[i]) begin
            runRow(rows[i]);
        end
        $display("Regression passed");
        $finish;
    end

    // 200 cycles per table row
    initial begin
        wait (tableReady);
        repeat (rows.size() * 200) @(posedge clk80);
        $display("Watchdog timeout: the table did not complete within %0d cycles",
            rows.size() * 200);
        $display("Regression failed");
        $fatal(1);
    end

endmodule

//--- build.f
+incdir+common
common/u712Pkg.sv
design/busSteering.sv
regCycle/regCycle.sv
chipRam/chipRam.sv
design/cycleTerm.sv
design/u712Top.sv
sim/u712Tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= u712Tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
